// ==== blob_fetch.sv ====
`default_nettype none

`include "blob_sort_consts.svh"

module blob_fetch (
	input wire clk,
	input wire reset,
	input wire enable,
	input wire blob_sort_pkg::sort_mode_t mode,
	input wire [`BS_COUNT_W-1:0] blob_count,
	output logic [`BS_ADDR_W-1:0] mem_addr,
	input wire [`BS_DATA_W-1:0] mem_rdata,
	input wire busy,
	output logic blob_strobe,
	output blob_sort_pkg::blob_key_t new_key,
	output logic [2:0] new_slot,
	output logic [`BS_PTR_W-1:0] new_ptr,
	output logic [4:0] valid_count,
	output logic done
);
	import blob_sort_pkg::*;

	localparam logic [2:0] st_idle = 3'd0;
	localparam logic [2:0] st_wait = 3'd1; // ranker busy, hold off
	localparam logic [2:0] st_addr = 3'd2;
	localparam logic [2:0] st_word0 = 3'd3;
	localparam logic [2:0] st_word1 = 3'd4;
	localparam logic [2:0] st_done = 3'd5;

	logic [2:0] state;
	logic [`BS_COUNT_W-1:0] rec_idx; // records finished so far
	logic [`BS_ADDR_W-1:0] rec_addr; // word 0 of the current record
	logic [7:0] slot_byte;
	logic slot_ok;
	logic last_rec;

	assign slot_byte = mem_rdata[7:0];
	assign slot_ok = (slot_byte != 8'd0) && (slot_byte <= 8'(`BS_NUM_SLOTS));
	assign last_rec = (rec_idx + 1'b1) == blob_count;

	// memory answers one cycle later, so word 1 is addressed while word 0 comes back
	assign mem_addr = (state == st_word0) ? rec_addr + 1'b1 : rec_addr;

	assign blob_strobe = enable && (state == st_word1);
	assign new_ptr = rec_addr;
	assign done = enable && (state == st_done);

	always_comb begin
		new_key = '0;
		if (mode == size_biggest || mode == size_smallest) begin
			new_key.size = mem_rdata[15:0];
		end else begin
			new_key.cen.x = mem_rdata[31:24];
			new_key.cen.y = mem_rdata[23:16];
		end
	end

	always_ff @(posedge clk) begin
		if (reset || !enable) begin
			state <= st_idle;
			rec_idx <= '0;
			rec_addr <= `BS_ADDR_W'(`BS_BLOB_BASE);
			valid_count <= '0;
		end else begin
			case (state)
				st_idle: state <= st_wait; // busy shows up next cycle
				st_wait: begin
					if (!busy) begin
						state <= (rec_idx == blob_count) ? st_done : st_addr;
					end
				end
				st_addr: state <= st_word0;
				st_word0: begin
					if (slot_ok) begin
						if (valid_count != 5'd31) begin
							valid_count <= valid_count + 1'b1;
						end
						state <= st_word1;
					end else begin
						// rejected record, ranker is idle so go straight on
						rec_idx <= rec_idx + 1'b1;
						rec_addr <= rec_addr + `BS_ADDR_W'(`BS_RECORD_WORDS);
						state <= last_rec ? st_done : st_addr;
					end
				end
				st_word1: begin
					rec_idx <= rec_idx + 1'b1;
					rec_addr <= rec_addr + `BS_ADDR_W'(`BS_RECORD_WORDS);
					state <= st_wait;
				end
				st_done: state <= st_done; // held until enable drops
				default: state <= st_idle;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (state == st_word0) begin
			new_slot <= slot_byte[2:0];
		end
	end

endmodule

`default_nettype wire

// ==== blob_sort.f ====
+incdir+.
blob_sort_pkg.sv
blob_fetch.sv
rank_insert.sv
rank_table.sv
blob_sort_top.sv
tb_clock_gen.sv
tb_blob_sort.sv

// ==== blob_sort_consts.svh ====
`ifndef BLOB_SORT_CONSTS_SVH
`define BLOB_SORT_CONSTS_SVH

// main memory bus, read only
`define BS_ADDR_W 18
`define BS_DATA_W 32

`define BS_KEY_W 16 // size, or x and y centroid
`define BS_PTR_W 18 // word address of a record

// blob records as left by the extractor
`define BS_BLOB_BASE 200000
`define BS_RECORD_WORDS 3

// rank table layout: entry = rank * slots + slot - 1
`define BS_NUM_SLOTS 6
`define BS_NUM_RANKS 3
`define BS_TABLE_DEPTH 18
`define BS_TABLE_ADDR_W 5

// pointer returned for an entry that holds no blob
`define BS_EMPTY_PTR {`BS_PTR_W{1'b1}}

`define BS_COUNT_W 16

`endif

// ==== blob_sort_pkg.sv ====
`default_nettype none

`include "blob_sort_consts.svh"

package blob_sort_pkg;

	// ranking criterion, picked by the 2-bit mode input
	typedef enum logic [1:0] {
		size_biggest  = 2'd0,
		size_smallest = 2'd1,
		y_highest     = 2'd2,
		y_lowest      = 2'd3
	} sort_mode_t;

	// one key word, read as a size in the size modes
	// and as a centroid pair in the y modes
	typedef union packed {
		logic [`BS_KEY_W-1:0] size;
		struct packed {
			logic [7:0] x; // high byte
			logic [7:0] y;
		} cen;
	} blob_key_t;

endpackage

`default_nettype wire

// ==== blob_sort_top.sv ====
`default_nettype none

`include "blob_sort_consts.svh"

module blob_sort_top (
	input wire clk,
	input wire reset,
	input wire enable,
	input wire blob_sort_pkg::sort_mode_t mode,
	input wire [`BS_COUNT_W-1:0] blob_count,
	output logic [`BS_ADDR_W-1:0] mem_addr,
	input wire [`BS_DATA_W-1:0] mem_rdata,
	input wire [`BS_TABLE_ADDR_W-1:0] ptr_rd_addr,
	output logic [`BS_PTR_W-1:0] ptr_rd_data,
	output logic [4:0] valid_count,
	output logic done
);
	import blob_sort_pkg::*;

	// fetch to ranker
	logic busy;
	logic blob_strobe;
	blob_key_t new_key;
	logic [2:0] new_slot;
	logic [`BS_PTR_W-1:0] new_ptr;

	// ranker to table
	logic [`BS_TABLE_ADDR_W-1:0] tab_addr;
	logic tab_we;
	blob_key_t tab_wkey;
	logic tab_wvalid;
	logic [`BS_PTR_W-1:0] tab_wptr;
	blob_key_t tab_rkey;
	logic tab_rvalid;
	logic [`BS_PTR_W-1:0] tab_rptr;

	blob_fetch i_fetch (
		.clk(clk),
		.reset(reset),
		.enable(enable),
		.mode(mode),
		.blob_count(blob_count),
		.mem_addr(mem_addr),
		.mem_rdata(mem_rdata),
		.busy(busy),
		.blob_strobe(blob_strobe),
		.new_key(new_key),
		.new_slot(new_slot),
		.new_ptr(new_ptr),
		.valid_count(valid_count),
		.done(done)
	);

	rank_insert i_insert (
		.clk(clk),
		.reset(reset),
		.enable(enable),
		.mode(mode),
		.blob_strobe(blob_strobe),
		.new_key(new_key),
		.new_slot(new_slot),
		.new_ptr(new_ptr),
		.busy(busy),
		.tab_addr(tab_addr),
		.tab_we(tab_we),
		.tab_wkey(tab_wkey),
		.tab_wvalid(tab_wvalid),
		.tab_wptr(tab_wptr),
		.tab_rkey(tab_rkey),
		.tab_rvalid(tab_rvalid),
		.tab_rptr(tab_rptr)
	);

	rank_table i_table (
		.clk(clk),
		.tab_addr(tab_addr),
		.tab_we(tab_we),
		.tab_wkey(tab_wkey),
		.tab_wvalid(tab_wvalid),
		.tab_wptr(tab_wptr),
		.tab_rkey(tab_rkey),
		.tab_rvalid(tab_rvalid),
		.tab_rptr(tab_rptr),
		.ptr_rd_addr(ptr_rd_addr),
		.ptr_rd_data(ptr_rd_data)
	);

endmodule

`default_nettype wire

// ==== rank_insert.sv ====
`default_nettype none

`include "blob_sort_consts.svh"

module rank_insert (
	input wire clk,
	input wire reset,
	input wire enable,
	input wire blob_sort_pkg::sort_mode_t mode,
	input wire blob_strobe,
	input wire blob_sort_pkg::blob_key_t new_key,
	input wire [2:0] new_slot,
	input wire [`BS_PTR_W-1:0] new_ptr,
	output logic busy,
	output logic [`BS_TABLE_ADDR_W-1:0] tab_addr,
	output logic tab_we,
	output blob_sort_pkg::blob_key_t tab_wkey,
	output logic tab_wvalid,
	output logic [`BS_PTR_W-1:0] tab_wptr,
	input wire blob_sort_pkg::blob_key_t tab_rkey,
	input wire tab_rvalid,
	input wire [`BS_PTR_W-1:0] tab_rptr
);
	import blob_sort_pkg::*;

	localparam logic [2:0] st_idle = 3'd0;
	localparam logic [2:0] st_clear = 3'd1;
	localparam logic [2:0] st_ready = 3'd2;
	localparam logic [2:0] st_look = 3'd3; // address a rank of the slot
	localparam logic [2:0] st_cmp = 3'd4;
	localparam logic [2:0] st_shift_rd = 3'd5;
	localparam logic [2:0] st_shift_wr = 3'd6;
	localparam logic [2:0] st_write = 3'd7;

	localparam logic [1:0] last_rank = 2'(`BS_NUM_RANKS - 1);
	localparam logic [`BS_TABLE_ADDR_W-1:0] last_entry = `BS_TABLE_ADDR_W'(`BS_TABLE_DEPTH - 1);

	logic [2:0] state;
	logic [`BS_TABLE_ADDR_W-1:0] clr_cnt;
	logic [1:0] rank; // rank under test, later the shift destination
	logic [1:0] rank_up;
	logic [1:0] win_rank;
	blob_key_t key_q;
	logic [2:0] slot_q;
	logic [`BS_PTR_W-1:0] ptr_q;
	logic beats;
	logic new_wins;

	function automatic logic [`BS_TABLE_ADDR_W-1:0] entry_addr(input logic [1:0] r,
			input logic [2:0] s);
		entry_addr = `BS_TABLE_ADDR_W'(r) * `BS_TABLE_ADDR_W'(`BS_NUM_SLOTS)
			+ `BS_TABLE_ADDR_W'(s) - 1'b1;
	endfunction

	assign rank_up = rank - 2'd1;
	assign busy = (state != st_idle) && (state != st_ready);

	// strict compare, so an equal key stays below the stored one
	always_comb begin
		case (mode)
			size_biggest: beats = key_q.size > tab_rkey.size;
			size_smallest: beats = key_q.size < tab_rkey.size;
			y_highest: beats = key_q.cen.y > tab_rkey.cen.y;
			default: beats = key_q.cen.y < tab_rkey.cen.y;
		endcase
		new_wins = !tab_rvalid || beats; // an empty rank is always taken
	end

	always_comb begin
		tab_addr = entry_addr(rank, slot_q);
		tab_we = 1'b0;
		tab_wkey = key_q;
		tab_wvalid = 1'b1;
		tab_wptr = ptr_q;
		case (state)
			st_clear: begin
				tab_addr = clr_cnt;
				tab_we = 1'b1;
				tab_wkey = '0;
				tab_wvalid = 1'b0;
				tab_wptr = `BS_EMPTY_PTR;
			end
			st_shift_rd: tab_addr = entry_addr(rank_up, slot_q);
			st_shift_wr: begin
				// entry read last cycle moves one rank down
				tab_we = 1'b1;
				tab_wkey = tab_rkey;
				tab_wvalid = tab_rvalid;
				tab_wptr = tab_rptr;
			end
			st_write: begin
				tab_addr = entry_addr(win_rank, slot_q);
				tab_we = 1'b1;
			end
			default: ;
		endcase
	end

	always_ff @(posedge clk) begin
		if (reset || !enable) begin
			state <= st_idle;
			clr_cnt <= '0;
			rank <= '0;
		end else begin
			case (state)
				st_idle: begin
					clr_cnt <= '0;
					state <= st_clear;
				end
				st_clear: begin
					clr_cnt <= clr_cnt + 1'b1;
					if (clr_cnt == last_entry) begin
						state <= st_ready;
					end
				end
				st_ready: begin
					if (blob_strobe) begin
						rank <= '0;
						state <= st_look;
					end
				end
				st_look: state <= st_cmp;
				st_cmp: begin
					if (new_wins) begin
						if (rank == last_rank) begin
							state <= st_write; // nothing below to shift
						end else begin
							rank <= last_rank;
							state <= st_shift_rd;
						end
					end else if (rank == last_rank) begin
						state <= st_ready; // lost everywhere, table unchanged
					end else begin
						rank <= rank + 1'b1;
						state <= st_look;
					end
				end
				st_shift_rd: state <= st_shift_wr;
				st_shift_wr: begin
					if (rank_up == win_rank) begin
						state <= st_write;
					end else begin
						rank <= rank_up;
						state <= st_shift_rd;
					end
				end
				st_write: state <= st_ready;
				default: state <= st_idle;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (state == st_ready && blob_strobe) begin
			key_q <= new_key;
			slot_q <= new_slot;
			ptr_q <= new_ptr;
		end
		if (state == st_cmp && new_wins) begin
			win_rank <= rank;
		end
	end

endmodule

`default_nettype wire

// ==== rank_table.sv ====
`default_nettype none

`include "blob_sort_consts.svh"

module rank_table (
	input wire clk,
	input wire [`BS_TABLE_ADDR_W-1:0] tab_addr,
	input wire tab_we,
	input wire blob_sort_pkg::blob_key_t tab_wkey,
	input wire tab_wvalid,
	input wire [`BS_PTR_W-1:0] tab_wptr,
	output blob_sort_pkg::blob_key_t tab_rkey,
	output logic tab_rvalid,
	output logic [`BS_PTR_W-1:0] tab_rptr,
	input wire [`BS_TABLE_ADDR_W-1:0] ptr_rd_addr,
	output logic [`BS_PTR_W-1:0] ptr_rd_data
);
	localparam int entry_w = `BS_KEY_W + 1 + `BS_PTR_W;

	logic [entry_w-1:0] mem [`BS_TABLE_DEPTH]; // {key, valid, ptr}
	logic [entry_w-1:0] entry_b;
	logic in_range_b;

	// port a, read before write
	always_ff @(posedge clk) begin
		if (tab_we) begin
			mem[tab_addr] <= {tab_wkey, tab_wvalid, tab_wptr};
		end
		{tab_rkey, tab_rvalid, tab_rptr} <= mem[tab_addr];
	end

	assign entry_b = mem[ptr_rd_addr];
	assign in_range_b = ptr_rd_addr < `BS_TABLE_ADDR_W'(`BS_TABLE_DEPTH);

	// port b, pointers only
	always_ff @(posedge clk) begin
		if (in_range_b && entry_b[`BS_PTR_W]) begin
			ptr_rd_data <= entry_b[`BS_PTR_W-1:0];
		end else begin
			ptr_rd_data <= `BS_EMPTY_PTR; // empty or past the last entry
		end
	end

endmodule

`default_nettype wire

// ==== run_sim.sh ====
#!/bin/sh
# build and run the blob ranking testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing -j 0 -f blob_sort.f --top-module tb_blob_sort -o tb_blob_sort \
	&& ./obj_dir/tb_blob_sort > sim.log 2>&1
[ -f sim.log ] && cat sim.log
grep -qxF "=== PASS ===" sim.log && echo "simulation passed" \
	|| { echo "simulation failed"; exit 1; }

// ==== tb_blob_sort.sv ====
`default_nettype none

`include "blob_sort_consts.svh"

module tb_blob_sort;
	import blob_sort_pkg::*;

	localparam int clk_period = 20;
	localparam int max_recs = 40;
	localparam int total_recs = 30 + 26 + 24 + 33 + 5 + 12 + 9;
	localparam int watchdog_cycles = total_recs * 200 + 2000;
	localparam logic [`BS_PTR_W-1:0] empty_ptr = `BS_EMPTY_PTR;

	logic clk;
	logic reset;
	logic enable;
	sort_mode_t mode;
	logic [`BS_COUNT_W-1:0] blob_count;
	logic [`BS_ADDR_W-1:0] mem_addr;
	logic [`BS_DATA_W-1:0] mem_rdata;
	logic [`BS_TABLE_ADDR_W-1:0] ptr_rd_addr;
	logic [`BS_PTR_W-1:0] ptr_rd_data;
	logic [4:0] valid_count;
	logic done;

	logic [31:0] rec_mem [max_recs * 3]; // word 0, 1, 2 of each record
	logic [31:0] rng_state;
	logic [`BS_ADDR_W-1:0] addr_seen;
	int error_count;

	// expected rank table, entry = rank * 6 + slot - 1
	logic ref_valid [`BS_TABLE_DEPTH];
	logic [15:0] ref_key [`BS_TABLE_DEPTH];
	logic [`BS_PTR_W-1:0] ref_ptr [`BS_TABLE_DEPTH];
	int ref_count;

	tb_clock_gen #(.half_period(clk_period / 2)) i_clock (.clk(clk));

	blob_sort_top i_dut (
		.clk(clk),
		.reset(reset),
		.enable(enable),
		.mode(mode),
		.blob_count(blob_count),
		.mem_addr(mem_addr),
		.mem_rdata(mem_rdata),
		.ptr_rd_addr(ptr_rd_addr),
		.ptr_rd_data(ptr_rd_data),
		.valid_count(valid_count),
		.done(done)
	);

	function automatic logic [31:0] lcg_next(input logic [31:0] s);
		lcg_next = s * 32'd1664525 + 32'd1013904223;
	endfunction

	task automatic draw_random(output logic [31:0] v);
		rng_state = lcg_next(rng_state);
		v = rng_state;
	endtask

	function automatic logic [31:0] read_word(input logic [`BS_ADDR_W-1:0] addr);
		int offset;
		offset = int'(addr) - `BS_BLOB_BASE;
		if (offset >= 0 && offset < max_recs * 3) begin
			read_word = rec_mem[offset];
		end else begin
			read_word = {addr[13:0], addr} ^ 32'h5a5a_0000; // outside the records
		end
	endfunction

	// main memory, the word for an address comes back one cycle later
	initial begin
		mem_rdata = '0;
		forever begin
			@(negedge clk);
			addr_seen = mem_addr;
			@(posedge clk);
			#2;
			mem_rdata = read_word(addr_seen);
		end
	end

	task automatic check_value(input string name, input logic [31:0] got,
			input logic [31:0] exp);
		if (got !== exp) begin
			error_count++;
			$display("ERROR at %0t: %s is %0h, expected %0h", $time, name, got, exp);
			$display("=== FAIL ===");
			$fatal(1, "mismatch on %s", name);
		end
	endtask

	function automatic logic [15:0] key_of(input sort_mode_t m, input logic [31:0] word1);
		if (m == size_biggest || m == size_smallest) begin
			key_of = word1[15:0];
		end else begin
			key_of = {8'd0, word1[23:16]}; // y centroid only
		end
	endfunction

	function automatic logic wins_over(input sort_mode_t m, input logic [15:0] a,
			input logic [15:0] b);
		case (m)
			size_biggest, y_highest: wins_over = a > b;
			default: wins_over = a < b;
		endcase
	endfunction

	task automatic model_insert(input sort_mode_t m, input int slot, input logic [15:0] key,
			input logic [`BS_PTR_W-1:0] ptr);
		int win;
		int r;
		int e;
		win = -1;
		for (r = 0; r < 3; r++) begin
			e = r * 6 + slot - 1;
			if (win < 0 && (!ref_valid[e] || wins_over(m, key, ref_key[e]))) begin
				win = r;
			end
		end
		if (win >= 0) begin
			// lower ranks move down one place, rank 2 falls off
			for (r = 2; r > win; r--) begin
				e = r * 6 + slot - 1;
				ref_valid[e] = ref_valid[e - 6];
				ref_key[e] = ref_key[e - 6];
				ref_ptr[e] = ref_ptr[e - 6];
			end
			e = win * 6 + slot - 1;
			ref_valid[e] = 1'b1;
			ref_key[e] = key;
			ref_ptr[e] = ptr;
		end
	endtask

	task automatic build_model(input sort_mode_t m, input int n);
		int slot;
		for (int e = 0; e < `BS_TABLE_DEPTH; e++) begin
			ref_valid[e] = 1'b0;
			ref_key[e] = '0;
			ref_ptr[e] = empty_ptr;
		end
		ref_count = 0;
		for (int i = 0; i < n; i++) begin
			slot = int'(rec_mem[3 * i][7:0]);
			if (slot >= 1 && slot <= 6) begin
				if (ref_count < 31) begin
					ref_count++; // counter saturates
				end
				model_insert(m, slot, key_of(m, rec_mem[3 * i + 1]),
					`BS_PTR_W'(`BS_BLOB_BASE + 3 * i));
			end
		end
	endtask

	task automatic fill_random(input int n);
		logic [31:0] v;
		for (int i = 0; i < n; i++) begin
			draw_random(v);
			rec_mem[3 * i] = {v[15:0], v[31:24], 8'(v[31:16] % 16'd9)}; // slot 0 to 8
			draw_random(v);
			rec_mem[3 * i + 1] = v;
			draw_random(v);
			rec_mem[3 * i + 2] = v;
		end
	endtask

	task automatic fill_rejected(input int n);
		logic [31:0] v;
		logic [7:0] slot;
		for (int i = 0; i < n; i++) begin
			draw_random(v);
			case (v[31:30])
				2'd0: slot = 8'd0;
				2'd1: slot = 8'd7;
				2'd2: slot = 8'd8;
				default: slot = 8'h81; // low bits look like slot 1
			endcase
			rec_mem[3 * i] = {v[23:0], slot};
			rec_mem[3 * i + 1] = v;
			rec_mem[3 * i + 2] = ~v;
		end
	endtask

	// equal sizes in slots 2 and 5, one smaller and one bigger late arrival
	task automatic fill_ties();
		logic [31:0] v;
		logic [7:0] slot;
		logic [15:0] key;
		for (int i = 0; i < 9; i++) begin
			draw_random(v);
			slot = (i == 1 || i == 3 || i == 7 || i == 8) ? 8'd5 : 8'd2;
			key = (i == 6) ? 16'h0300 : (i == 8) ? 16'h0500 : 16'h0400;
			rec_mem[3 * i] = {v[31:8], slot};
			rec_mem[3 * i + 1] = {v[31:16], key};
			rec_mem[3 * i + 2] = v;
		end
	endtask

	task automatic run_and_check(input sort_mode_t m, input int n);
		logic [`BS_PTR_W-1:0] exp_ptr;
		build_model(m, n);
		@(posedge clk);
		#2;
		mode = m;
		blob_count = `BS_COUNT_W'(n);
		enable = 1'b1;
		@(posedge clk);
		#1;
		check_value("done", 32'(done), 32'd0);
		while (done !== 1'b1) begin
			@(posedge clk);
			#1;
		end
		check_value("valid_count", 32'(valid_count), 32'(ref_count));
		for (int a = 0; a < `BS_TABLE_DEPTH; a++) begin
			exp_ptr = ref_valid[a] ? ref_ptr[a] : empty_ptr;
			@(posedge clk);
			#2;
			ptr_rd_addr = `BS_TABLE_ADDR_W'(a);
			@(posedge clk);
			#1;
			check_value($sformatf("ptr_rd_data[%0d]", a), 32'(ptr_rd_data), 32'(exp_ptr));
		end
		check_value("done", 32'(done), 32'd1); // still held while enable is high
		@(posedge clk);
		#2;
		enable = 1'b0;
		@(posedge clk);
		#1;
		check_value("done", 32'(done), 32'd0);
		check_value("valid_count", 32'(valid_count), 32'd0);
	endtask

	initial begin
		#(watchdog_cycles * clk_period);
		$display("watchdog expired, the scan never finished in time");
		$display("=== FAIL ===");
		$fatal(1, "timeout");
	end

	initial begin
		error_count = 0;
		rng_state = 32'hd9fc_934e;
		reset = 1'b1;
		enable = 1'b0;
		mode = size_biggest;
		blob_count = '0;
		ptr_rd_addr = '0;
		repeat (4) @(posedge clk);
		#2;
		reset = 1'b0;

		fill_random(30);
		run_and_check(size_biggest, 30);
		fill_random(26);
		run_and_check(size_smallest, 26);
		fill_random(24);
		run_and_check(y_highest, 24);
		fill_random(33);
		run_and_check(y_lowest, 33);

		// restart with a short batch, the old ranks must be gone
		fill_random(5);
		run_and_check(size_biggest, 5);

		fill_rejected(12);
		run_and_check(y_highest, 12);

		fill_ties();
		run_and_check(size_biggest, 9);

		if (error_count == 0) begin
			$display("=== PASS ===");
			$finish;
		end else begin
			$display("=== FAIL ===");
			$fatal(1, "%0d checks failed", error_count);
		end
	end

endmodule

`default_nettype wire

// ==== tb_clock_gen.sv ====
`default_nettype none

module tb_clock_gen #(
	parameter int half_period = 10
) (
	output logic clk
);
	initial clk = 1'b0;

	always #half_period clk = ~clk; // toggles every half period

endmodule

`default_nettype wire
